// ==== hdl/nnPkg.sv ====
`default_nettype none

package nnPkg;

	// ##################################################################
	// Sizes and fixed-point format
	// ##################################################################

	localparam int numInputs = 15;
	localparam int numNeurons = 4;

	// The binary point sits above bit 12 of every activation and weight.
	localparam int fracBits = 13;
	localparam int outBits = 16;

	typedef logic [31:0] activation_t;
	typedef logic [31:0] weight_t;
	typedef logic [1:0] neuronIndex_t;
	typedef logic [3:0] inputIndex_t;

	typedef activation_t [numInputs-1:0] activationVector_t;
	typedef weight_t [numInputs-1:0] weightVector_t;

	typedef enum logic [1:0]
	{
		idle,
		run,
		drain
	} layerState_t;

	// ##################################################################
	// Trained parameters, one row per neuron
	// ##################################################################

	localparam weight_t weightTable [numNeurons][numInputs] = '{
		'{1485, -5035, -767, 149, 2557, 1782, -358, 5223,
			2001, 2225, -2127, -4454, 3126, -2552, 3042},
		'{-2210, 3318, 1027, -4120, 688, -1502, 2764, -391,
			4015, -2873, 1190, 3561, -844, 2236, -1679},
		'{3904, -1186, -2645, 1753, -3377, 502, 4480, -2019,
			-733, 1328, -4902, 2687, 915, -1458, 3073},
		'{-871, 2094, 4631, -3512, 1267, -2308, -1044, 3395,
			-2761, 587, 2950, -1233, -4187, 1806, 742}
	};

	// Biases are added once per neuron after the products are summed.
	localparam weight_t biasTable [numNeurons] = '{1243, -860, 2175, 410};

endpackage

`default_nettype wire

// ==== hdl/nodeIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface nodeIf;
	import nnPkg::*;

	logic issue;
	neuronIndex_t neuronIndex;
	weightVector_t weights;
	weight_t bias;

	logic resultValid;
	neuronIndex_t resultIndex;
	activation_t result;

	modport issuer (output issue, neuronIndex, weights, bias);

	modport compute (input issue, neuronIndex, weights, bias,
		output resultValid, resultIndex, result);

	// The controller only watches for the last result to come back.
	modport monitor (input resultValid, resultIndex);
endinterface

`default_nettype wire

// ==== hdl/inputBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module inputBuffer
(
	input wire logic clk,
	input wire logic reset,
	input wire logic loadEnable,
	input wire logic inValid,
	input nnPkg::activation_t inData,
	input wire logic rewind,
	output nnPkg::activationVector_t activations
);
	import nnPkg::*;

	inputIndex_t writePtr;
	logic writeEnable;

	// Extra words after the fifteenth fall off the end.
	assign writeEnable = loadEnable && inValid && (writePtr < inputIndex_t'(numInputs));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			writePtr <= '0;
			activations <= '0;
		end
		else if (rewind)
		begin
			writePtr <= '0;
		end
		else if (writeEnable)
		begin
			activations[writePtr] <= inData;
			writePtr <= writePtr + 1'b1;
		end
	end
endmodule

`default_nettype wire

// ==== hdl/neuronCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module neuronCounter
(
	input wire logic clk,
	input wire logic reset,
	input wire logic clear,
	input wire logic step,
	output nnPkg::neuronIndex_t index,
	output logic last
);
	import nnPkg::*;

	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			index <= '0;
		end
		else if (step)
		begin
			index <= index + 1'b1;
		end
	end

	assign last = (index == neuronIndex_t'(numNeurons - 1));
endmodule

`default_nettype wire

// ==== hdl/layerControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module layerControl
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic counterLast,
	nodeIf.monitor node,
	output logic loadEnable,
	output logic rewind,
	output logic counterClear,
	output logic read,
	output logic busy
);
	import nnPkg::*;

	layerState_t state;
	logic accept;
	logic lastResult;

	assign accept = (state == idle) && start;
	assign loadEnable = (state == idle);
	assign rewind = accept;
	assign counterClear = accept;

	assign lastResult = node.resultValid &&
		(node.resultIndex == neuronIndex_t'(numNeurons - 1));

	// ##################################################################
	// Run sequencing
	// ##################################################################

	// read is registered, so each strobe lines up with the counter value it
	// steps past.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			busy <= 1'b0;
			read <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (accept)
					begin
						state <= run;
						busy <= 1'b1;
					end
				end
				run:
				begin
					if (read && counterLast)
					begin
						read <= 1'b0;
						state <= drain;
					end
					else
					begin
						read <= 1'b1;
					end
				end
				drain:
				begin
					// Up to three neurons are still in the node here.
					if (lastResult)
					begin
						state <= idle;
						busy <= 1'b0;
					end
				end
				default:
				begin
					state <= idle;
					busy <= 1'b0;
					read <= 1'b0;
				end
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== hdl/weightRom.sv ====
`timescale 1ns/100ps
`default_nettype none

module weightRom
(
	input wire logic clk,
	input wire logic reset,
	input wire logic read,
	input nnPkg::neuronIndex_t index,
	nodeIf.issuer node
);
	import nnPkg::*;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			node.issue <= 1'b0;
		end
		else
		begin
			node.issue <= read;
		end
	end

	// The row is picked up on the read strobe and held until the next one.
	always_ff @(posedge clk)
	begin
		if (read)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				node.weights[i] <= weightTable[index][i];
			end
			node.bias <= biasTable[index];
			node.neuronIndex <= index;
		end
	end
endmodule

`default_nettype wire

// ==== hdl/neuronNode.sv ====
`timescale 1ns/100ps
`default_nettype none

module neuronNode
(
	input wire logic clk,
	input wire logic reset,
	input nnPkg::activationVector_t activations,
	nodeIf.compute node
);
	import nnPkg::*;

	activation_t products [numInputs];
	weight_t biasHold;
	neuronIndex_t index1;
	logic valid1;

	activation_t sum;
	activation_t sumComb;
	neuronIndex_t index2;
	logic valid2;

	// ##################################################################
	// Stage 1: products
	// ##################################################################

	// Only the low 32 bits of each product are kept, which makes the
	// unsigned multiply give the same bits as a signed one.
	always_ff @(posedge clk)
	begin
		if (node.issue)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				products[i] <= activations[i] * node.weights[i];
			end
			biasHold <= node.bias;
			index1 <= node.neuronIndex;
		end
	end

	// ##################################################################
	// Stage 2: sum with bias
	// ##################################################################

	always_comb
	begin
		sumComb = biasHold;
		for (int i = 0; i < numInputs; i++)
		begin
			sumComb = sumComb + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		sum <= sumComb;
		index2 <= index1;
	end

	// ##################################################################
	// Stage 3: rectify and slice
	// ##################################################################

	always_ff @(posedge clk)
	begin
		if (sum[31])
		begin
			node.result <= '0;
		end
		else
		begin
			node.result <= activation_t'(sum[fracBits+outBits-1:fracBits]);
		end
		node.resultIndex <= index2;
	end

	// Valid travels alongside the data so a new neuron can enter every cycle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			node.resultValid <= 1'b0;
		end
		else
		begin
			valid1 <= node.issue;
			valid2 <= valid1;
			node.resultValid <= valid2;
		end
	end
endmodule

`default_nettype wire

// ==== hdl/hiddenLayer.sv ====
`timescale 1ns/100ps
`default_nettype none

module hiddenLayer
(
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input nnPkg::activation_t inData,
	input wire logic start,
	output logic busy,
	output logic outValid,
	output nnPkg::neuronIndex_t outIndex,
	output nnPkg::activation_t outData
);
	import nnPkg::*;

	activationVector_t activations;
	neuronIndex_t counterIndex;
	logic counterLast;
	logic counterClear;
	logic loadEnable;
	logic rewind;
	logic read;

	nodeIf nodeBus ();

	inputBuffer i_inputBuffer (.clk, .reset, .loadEnable, .inValid, .inData, .rewind,
		.activations);

	neuronCounter i_neuronCounter (.clk, .reset, .clear(counterClear), .step(read),
		.index(counterIndex), .last(counterLast));

	layerControl i_layerControl (.clk, .reset, .start, .counterLast, .node(nodeBus.monitor),
		.loadEnable, .rewind, .counterClear, .read, .busy);

	weightRom i_weightRom (.clk, .reset, .read, .index(counterIndex),
		.node(nodeBus.issuer));

	neuronNode i_neuronNode (.clk, .reset, .activations, .node(nodeBus.compute));

	// Results leave as strobes; the host has to take them as they come.
	assign outValid = nodeBus.resultValid;
	assign outIndex = nodeBus.resultIndex;
	assign outData = nodeBus.result;
endmodule

`default_nettype wire

// ==== sim/tbHiddenLayer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbHiddenLayer;
	import nnPkg::*;

	// The 16 runs take about 420 cycles, so this limit leaves ample room.
	localparam int timeoutCycles = 2000;
	localparam int startToResult = 5;

	logic clk;
	logic reset;
	logic inValid;
	activation_t inData;
	logic start;
	logic busy;
	logic outValid;
	neuronIndex_t outIndex;
	activation_t outData;

	activation_t bufferModel [numInputs];
	activation_t expected [numNeurons];
	int modelPtr;
	int cycleCount;

	hiddenLayer i_hiddenLayer (.clk, .reset, .inValid, .inData, .start, .busy, .outValid,
		.outIndex, .outData);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun();
		$display("tests failed");
		$fatal(1, "Stopped at the first error.");
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			abortRun();
		end
	end

	// ##################################################################
	// Reference model
	// ##################################################################

	// Products and the sum wrap at 32 bits; a negative sum rectifies to zero.
	function automatic activation_t modelNeuron(input int neuron);
		logic [63:0] product;
		logic [31:0] acc;
		acc = biasTable[neuron];
		for (int i = 0; i < numInputs; i++)
		begin
			product = longint'($signed(bufferModel[i])) *
				longint'($signed(weightTable[neuron][i]));
			acc = acc + product[31:0];
		end
		if (acc[31])
			return '0;
		return (acc >> fracBits) & ((32'd1 << outBits) - 32'd1);
	endfunction

	// ##################################################################
	// Host side tasks
	// ##################################################################

	task automatic loadWord(input activation_t word);
		@(negedge clk);
		inValid = 1'b1;
		inData = word;
		if (modelPtr < numInputs)
		begin
			bufferModel[modelPtr] = word;
			modelPtr = modelPtr + 1;
		end
	endtask

	task automatic stopLoad();
		@(negedge clk);
		inValid = 1'b0;
	endtask

	// With disturb set, the host keeps strobing inValid and start while busy.
	task automatic runNeurons(input bit disturb);
		int edges;
		int got;
		for (int n = 0; n < numNeurons; n++)
			expected[n] = modelNeuron(n);
		@(negedge clk);
		assert (busy == 1'b0) else
		begin
			$display("Start was issued while the layer was still busy");
			abortRun();
		end
		start = 1'b1;
		modelPtr = 0;
		@(negedge clk);
		start = 1'b0;
		assert (busy == 1'b1) else
		begin
			$display("MISMATCH busy after start: got %h expected 1", busy);
			abortRun();
		end
		edges = 0;
		got = 0;
		while (got < numNeurons || busy)
		begin
			if (outValid)
			begin
				assert (got < numNeurons) else
				begin
					$display("More than four results came out of one run");
					abortRun();
				end
				assert (got != 0 || edges == startToResult) else
				begin
					$display("First result came %0d cycles after start instead of %0d",
						edges, startToResult);
					abortRun();
				end
				assert (outIndex == neuronIndex_t'(got)) else
				begin
					$display("MISMATCH outIndex: got %h expected %h", outIndex, got);
					abortRun();
				end
				assert (outData == expected[got]) else
				begin
					$display("MISMATCH outData neuron %0d: got %h expected %h", got,
						outData, expected[got]);
					abortRun();
				end
				got = got + 1;
			end
			else
			begin
				assert (got == 0 || got == numNeurons) else
				begin
					$display("Results were not on consecutive cycles");
					abortRun();
				end
			end
			inValid = disturb && busy;
			start = disturb && busy;
			inData = $urandom;
			@(negedge clk);
			edges = edges + 1;
		end
		inValid = 1'b0;
		start = 1'b0;
		assert (edges == startToResult + numNeurons) else
		begin
			$display("Busy fell %0d cycles after start instead of %0d", edges,
				startToResult + numNeurons);
			abortRun();
		end
	endtask

	// ##################################################################
	// Directed tests
	// ##################################################################

	task automatic idleAfterReset();
		repeat (20)
		begin
			@(negedge clk);
			assert (busy == 1'b0 && outValid == 1'b0) else
			begin
				$display("MISMATCH busy/outValid while idle: got %h/%h expected 0/0",
					busy, outValid);
				abortRun();
			end
		end
		runNeurons(1'b0);
	endtask

	task automatic smallPositiveRun();
		// Two extra words check that the buffer stops at fifteen.
		for (int i = 0; i < numInputs + 2; i++)
			loadWord(activation_t'((i + 1) * 256));
		stopLoad();
		runNeurons(1'b0);
	endtask

	task automatic negativeSumRun();
		// Only input 1 is set, at 1.0, so the sign of each row's weight 1 decides.
		for (int i = 0; i < numInputs; i++)
			loadWord((i == 1) ? activation_t'(32'd8192) : '0);
		stopLoad();
		runNeurons(1'b0);
	endtask

	task automatic randomWrapRuns();
		repeat (10)
		begin
			for (int i = 0; i < numInputs; i++)
				loadWord($urandom);
			stopLoad();
			runNeurons(1'b0);
		end
	endtask

	task automatic busyIgnoresHost();
		for (int i = 0; i < numInputs; i++)
			loadWord($urandom);
		stopLoad();
		runNeurons(1'b1);
		runNeurons(1'b0);
	endtask

	task automatic partialReloadRun();
		for (int i = 0; i < 5; i++)
			loadWord($urandom);
		stopLoad();
		runNeurons(1'b0);
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		start = 1'b0;
		cycleCount = 0;
		modelPtr = 0;
		for (int i = 0; i < numInputs; i++)
			bufferModel[i] = '0;
		void'($urandom(86));
		repeat (3) @(negedge clk);
		reset = 1'b0;

		idleAfterReset();
		smallPositiveRun();
		negativeSumRun();
		randomWrapRuns();
		busyIgnoresHost();
		partialReloadRun();

		$display("all tests passed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/nnPkg.sv
hdl/nodeIf.sv
hdl/inputBuffer.sv
hdl/neuronCounter.sv
hdl/layerControl.sv
hdl/weightRom.sv
hdl/neuronNode.sv
hdl/hiddenLayer.sv
sim/tbHiddenLayer.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tbHiddenLayer
RTL_TOP   = hiddenLayer
FILELIST  = verilog.f
BUILD_DIR = obj_dir
PASS_TEXT = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
